/* decode_pkg.sv */
// Decode package with RV32I encodings, the instruction word views and the stage structs
`default_nettype none

package decode_pkg;

    localparam int XLEN = 32;  // Data width

    typedef logic [4:0] reg_addr_t;
    typedef logic [4:0] uop_t;

    // Instruction word views
    // --------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_hi;  // I immediate, or S/B upper bits
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        logic [4:0]  lo;      // rd, or S/B lower bits
        logic [6:0]  opcode;
    } is_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        is_fmt_t is;
    } instr_u;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // Micro-op codes
    // --------------------
    localparam uop_t ALU_ADD  = 5'd1;
    localparam uop_t ALU_SUB  = 5'd2;
    localparam uop_t ALU_AND  = 5'd3;
    localparam uop_t ALU_OR   = 5'd4;
    localparam uop_t ALU_XOR  = 5'd5;
    localparam uop_t ALU_SLT  = 5'd6;
    localparam uop_t ALU_SLTU = 5'd7;
    localparam uop_t ALU_SLL  = 5'd8;
    localparam uop_t ALU_SRL  = 5'd9;
    localparam uop_t ALU_SRA  = 5'd10;

    localparam uop_t CFU_BEQ  = 5'd1;
    localparam uop_t CFU_BNE  = 5'd2;
    localparam uop_t CFU_BLT  = 5'd3;
    localparam uop_t CFU_BGE  = 5'd4;
    localparam uop_t CFU_BLTU = 5'd5;
    localparam uop_t CFU_BGEU = 5'd6;
    localparam uop_t CFU_JALI = 5'd7;
    localparam uop_t CFU_JALR = 5'd8;

    // LSU micro-op is a set of bit fields
    localparam int         LSU_LOAD   = 0;      // Bit index
    localparam int         LSU_STORE  = 3;      // Bit index
    localparam int         LSU_SIGNED = 4;      // Bit index
    localparam logic [1:0] LSU_BYTE   = 2'b01;  // Width in bits 2:1
    localparam logic [1:0] LSU_HALF   = 2'b10;
    localparam logic [1:0] LSU_WORD   = 2'b11;

    // Decode results
    // --------------------
    typedef struct packed {
        logic alu;
        logic lsu;
        logic cfu;
    } fu_t;

    typedef struct packed {
        logic a_rs1;
        logic a_pcim;
        logic a_zero;
        logic b_rs2;
        logic b_imm;
        logic b_zero;
        logic c_rs2;
        logic c_pcim;
    } opr_src_t;

    typedef struct packed {
        fu_t       fu;
        uop_t      uop;
        reg_addr_t rd;
        opr_src_t  opr_src;
        logic      use_rs1;
        logic      use_rs2;
        logic      illegal;
    } dec_ctl_t;

    typedef struct packed {
        logic [XLEN-1:0] imm;     // General immediate
        logic [XLEN-1:0] imm_pc;  // Added to the PC
    } dec_imm_t;

    typedef struct packed {
        reg_addr_t       rd;     // Trap cause when trap is set
        uop_t            uop;
        fu_t             fu;
        logic            trap;
        logic [XLEN-1:0] opr_a;
        logic [XLEN-1:0] opr_b;
        logic [XLEN-1:0] opr_c;
    } dec_out_t;

    localparam reg_addr_t TRAP_IACCESS = 5'd1;  // Fetch error
    localparam reg_addr_t TRAP_IOPCODE = 5'd2;  // Illegal encoding

endpackage

`default_nettype wire

/* decode_control.sv */
// Control decoder turning an RV32I word into unit, micro-op, destination and operand sources
`default_nettype none
`timescale 1ns/10ps

module decode_control (
    input  decode_pkg::instr_u   i_instr,  // Word being decoded
    output decode_pkg::dec_ctl_t o_ctl     // Control fields toward the stage
);
    import decode_pkg::*;

    r_fmt_t   f;      // Register-format view
    logic     alt;    // funct7 selects SUB/SRA
    fu_t      fu;
    uop_t     uop;
    opr_src_t src;
    logic     rd_en;  // Instruction writes rd
    logic     legal;

    assign f   = i_instr.r;
    assign alt = (f.funct7 == 7'b0100000);

    function automatic uop_t alu_uop(input logic [2:0] funct3, input logic alt_op);
        case (funct3)
            3'b000:  return alt_op ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt_op ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic uop_t cfu_uop(input logic [2:0] funct3);
        case (funct3)
            3'b000:  return CFU_BEQ;
            3'b001:  return CFU_BNE;
            3'b100:  return CFU_BLT;
            3'b101:  return CFU_BGE;
            3'b110:  return CFU_BLTU;
            default: return CFU_BGEU;
        endcase
    endfunction

    function automatic logic [1:0] lsu_width(input logic [1:0] size);
        case (size)
            2'b00:   return LSU_BYTE;
            2'b01:   return LSU_HALF;
            default: return LSU_WORD;
        endcase
    endfunction

    // Opcode classification
    // --------------------
    always_comb begin
        fu    = '0;
        uop   = '0;
        src   = '0;
        rd_en = 1'b0;
        legal = 1'b0;
        case (f.opcode)
            OPC_OP: begin
                legal     = (f.funct7 == 7'd0) ||
                            (alt && (f.funct3 == 3'b000 || f.funct3 == 3'b101));
                fu.alu    = 1'b1;
                uop       = alu_uop(f.funct3, alt);
                src.a_rs1 = 1'b1;
                src.b_rs2 = 1'b1;
                rd_en     = 1'b1;
            end
            OPC_OP_IMM: begin
                if (f.funct3 == 3'b001) begin
                    legal = (f.funct7 == 7'd0);          // SLLI
                end else if (f.funct3 == 3'b101) begin
                    legal = (f.funct7 == 7'd0) || alt;   // SRLI/SRAI
                end else begin
                    legal = 1'b1;
                end
                fu.alu    = 1'b1;
                uop       = alu_uop(f.funct3, alt && f.funct3 == 3'b101);
                src.a_rs1 = 1'b1;
                src.b_imm = 1'b1;
                rd_en     = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                legal      = 1'b1;
                fu.alu     = 1'b1;
                uop        = (f.opcode == OPC_LUI) ? ALU_OR : ALU_ADD;
                src.a_zero = (f.opcode == OPC_LUI);
                src.b_imm  = (f.opcode == OPC_LUI);
                src.a_pcim = (f.opcode == OPC_AUIPC);
                src.b_zero = (f.opcode == OPC_AUIPC);
                rd_en      = 1'b1;
            end
            OPC_LOAD: begin
                legal           = (f.funct3[1:0] != 2'b11) && (f.funct3 != 3'b110);
                fu.lsu          = 1'b1;
                uop[LSU_LOAD]   = 1'b1;
                uop[2:1]        = lsu_width(f.funct3[1:0]);
                uop[LSU_SIGNED] = !f.funct3[2];  // LB and LH
                src.a_rs1       = 1'b1;
                src.b_imm       = 1'b1;
                rd_en           = 1'b1;
            end
            OPC_STORE: begin
                legal          = !f.funct3[2] && (f.funct3[1:0] != 2'b11);
                fu.lsu         = 1'b1;
                uop[LSU_STORE] = 1'b1;
                uop[2:1]       = lsu_width(f.funct3[1:0]);
                src.a_rs1      = 1'b1;
                src.b_imm      = 1'b1;
                src.c_rs2      = 1'b1;  // Store data
            end
            OPC_BRANCH: begin
                legal      = (f.funct3[2:1] != 2'b01);
                fu.cfu     = 1'b1;
                uop        = cfu_uop(f.funct3);
                src.a_rs1  = 1'b1;
                src.b_rs2  = 1'b1;
                src.c_pcim = 1'b1;  // Branch target
            end
            OPC_JAL: begin
                legal      = 1'b1;
                fu.cfu     = 1'b1;
                uop        = CFU_JALI;
                src.a_zero = 1'b1;
                src.b_zero = 1'b1;
                src.c_pcim = 1'b1;
                rd_en      = 1'b1;
            end
            OPC_JALR: begin
                legal     = (f.funct3 == 3'b000);
                fu.cfu    = 1'b1;
                uop       = CFU_JALR;
                src.a_rs1 = 1'b1;
                src.b_imm = 1'b1;
                rd_en     = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // Illegal words carry no unit, micro-op or sources
    always_comb begin
        o_ctl         = '0;
        o_ctl.illegal = !legal;
        if (legal) begin
            o_ctl.fu      = fu;
            o_ctl.uop     = uop;
            o_ctl.rd      = rd_en ? f.rd : 5'd0;
            o_ctl.opr_src = src;
            o_ctl.use_rs1 = src.a_rs1;
            o_ctl.use_rs2 = src.b_rs2 | src.c_rs2;
        end
    end

    always_comb begin
        assert ($onehot0(o_ctl.fu))
            else $error("decode_control: unit select not one-hot for %h", i_instr);
    end

endmodule

`default_nettype wire

/* decode_immediate.sv */
// Immediate extractor building the RV32I immediates and selecting them by opcode
`default_nettype none
`timescale 1ns/10ps

module decode_immediate (
    input  decode_pkg::instr_u   i_instr,  // Word being decoded
    output decode_pkg::dec_imm_t o_imm     // General and PC-relative immediates
);
    import decode_pkg::*;

    is_fmt_t         w;          // I/S-format view
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_sh;     // Shift amount
    logic            shift_imm;  // SLLI, SRLI, SRAI
    logic            sign;

    assign w    = i_instr.is;
    assign sign = w.imm_hi[11];

    // Field extraction
    // --------------------
    assign imm_i  = {{20{sign}}, w.imm_hi};
    assign imm_s  = {{20{sign}}, w.imm_hi[11:5], w.lo};
    assign imm_b  = {{20{sign}}, w.lo[0], w.imm_hi[10:5], w.lo[4:1], 1'b0};
    assign imm_u  = {w.imm_hi, w.rs1, w.funct3, 12'b0};
    assign imm_j  = {{12{sign}}, w.rs1, w.funct3, w.imm_hi[0], w.imm_hi[10:1], 1'b0};
    assign imm_sh = {27'b0, w.imm_hi[4:0]};

    assign shift_imm = (w.opcode == OPC_OP_IMM) && (w.funct3[1:0] == 2'b01);

    // Selection
    // --------------------
    always_comb begin
        case (w.opcode)
            OPC_BRANCH: o_imm.imm_pc = imm_b;
            OPC_JAL:    o_imm.imm_pc = imm_j;
            OPC_AUIPC:  o_imm.imm_pc = imm_u;
            default:    o_imm.imm_pc = '0;
        endcase
    end

    always_comb begin
        if (shift_imm) begin
            o_imm.imm = imm_sh;
        end else begin
            case (w.opcode)
                OPC_OP_IMM, OPC_LOAD, OPC_JALR: o_imm.imm = imm_i;
                OPC_STORE:                      o_imm.imm = imm_s;
                OPC_LUI:                        o_imm.imm = imm_u;
                default:                        o_imm.imm = o_imm.imm_pc;
            endcase
        end
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
// Decode stage register with program counter, operand assembly and trap forming
`default_nettype none
`timescale 1ns/10ps

module decode_stage #(
    parameter logic [decode_pkg::XLEN-1:0] PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic                          g_clk,
    input  logic                          g_resetn,

    input  logic                          i_s1_valid,   // Fetch word valid
    input  logic                          i_s1_error,   // Fetch error on this word
    input  logic                          i_s1_flush,   // Drop stage contents
    output logic                          o_s1_busy,    // Stage cannot accept

    input  decode_pkg::dec_ctl_t          i_ctl,
    input  decode_pkg::dec_imm_t          i_imm,
    input  logic [decode_pkg::XLEN-1:0]   i_rs1_rdata,
    input  logic [decode_pkg::XLEN-1:0]   i_rs2_rdata,

    input  logic                          i_cf_req,     // Redirect request
    input  logic [decode_pkg::XLEN-1:0]   i_cf_target,
    input  logic                          i_cf_ack,

    output logic                          o_s2_valid,
    output decode_pkg::dec_out_t          o_s2,
    input  logic                          i_s2_busy
);
    import decode_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_imm;   // PC plus PC-relative immediate
    logic            accept;   // Word taken this edge
    logic            trap;
    dec_out_t        s2_next;

    assign o_s1_busy = o_s2_valid && i_s2_busy;
    assign accept    = i_s1_valid && !o_s1_busy;

    // Program counter
    // --------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= PC_RESET_VALUE;
        end else if (i_cf_req && i_cf_ack) begin
            pc <= i_cf_target;             // Redirect wins
        end else if (accept && !i_s1_flush) begin
            pc <= pc + 32'd4;
        end
    end

    assign pc_imm = pc + i_imm.imm_pc;

    // Operand assembly
    // --------------------
    always_comb begin
        if (i_ctl.opr_src.a_zero) begin
            s2_next.opr_a = '0;
        end else if (i_ctl.opr_src.a_pcim) begin
            s2_next.opr_a = pc_imm;
        end else if (i_ctl.opr_src.a_rs1) begin
            s2_next.opr_a = i_rs1_rdata;
        end else begin
            s2_next.opr_a = '0;
        end

        if (i_ctl.opr_src.b_zero) begin
            s2_next.opr_b = '0;
        end else if (i_ctl.opr_src.b_imm) begin
            s2_next.opr_b = i_imm.imm;
        end else if (i_ctl.opr_src.b_rs2) begin
            s2_next.opr_b = i_rs2_rdata;
        end else begin
            s2_next.opr_b = '0;
        end

        s2_next.opr_c = ({XLEN{i_ctl.opr_src.c_rs2}}  & i_rs2_rdata) |
                        ({XLEN{i_ctl.opr_src.c_pcim}} & pc_imm);
    end

    // Trap cause goes out in rd with fetch error first
    assign trap         = i_s1_error || i_ctl.illegal;
    assign s2_next.trap = trap;
    assign s2_next.rd   = i_s1_error    ? TRAP_IACCESS :
                          i_ctl.illegal ? TRAP_IOPCODE :
                                          i_ctl.rd;
    assign s2_next.uop  = trap ? 5'd0 : i_ctl.uop;
    assign s2_next.fu   = trap ? '0   : i_ctl.fu;

    // Stage register
    // --------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_s1_flush) begin
            o_s2_valid <= 1'b0;
        end else if (!o_s1_busy) begin
            o_s2_valid <= i_s1_valid;  // Refill as the old item leaves
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            o_s2 <= s2_next;
        end
    end

    // Stalled output must not move
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_s2_valid && i_s2_busy |=> $stable(o_s2))
        else $error("decode_stage: o_s2 changed under back-pressure");

endmodule

`default_nettype wire

/* frv_decode.sv */
// Top level of the RV32I decode stage, joining the two decoders and the stage register
`default_nettype none
`timescale 1ns/10ps

module frv_decode #(
    parameter logic [decode_pkg::XLEN-1:0] PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic                          g_clk,
    input  logic                          g_resetn,

    input  logic                          i_s1_valid,
    input  logic [decode_pkg::XLEN-1:0]   i_s1_data,    // Instruction word
    input  logic                          i_s1_error,
    input  logic                          i_s1_flush,
    output logic                          o_s1_busy,

    output decode_pkg::reg_addr_t         o_rs1_addr,   // Zero when unused
    output decode_pkg::reg_addr_t         o_rs2_addr,
    input  logic [decode_pkg::XLEN-1:0]   i_rs1_rdata,
    input  logic [decode_pkg::XLEN-1:0]   i_rs2_rdata,

    input  logic                          i_cf_req,
    input  logic [decode_pkg::XLEN-1:0]   i_cf_target,
    input  logic                          i_cf_ack,

    output logic                          o_s2_valid,
    output decode_pkg::dec_out_t          o_s2,
    input  logic                          i_s2_busy
);
    import decode_pkg::*;

    instr_u   instr;
    dec_ctl_t ctl;
    dec_imm_t imm;

    assign instr = i_s1_data;

    // Register file addressing
    assign o_rs1_addr = ctl.use_rs1 ? instr.r.rs1 : 5'd0;
    assign o_rs2_addr = ctl.use_rs2 ? instr.r.rs2 : 5'd0;

    decode_control i_decode_control (
        .i_instr (instr),
        .o_ctl   (ctl)
    );

    decode_immediate i_decode_immediate (
        .i_instr (instr),
        .o_imm   (imm)
    );

    decode_stage #(
        .PC_RESET_VALUE (PC_RESET_VALUE)
    ) i_decode_stage (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_s1_valid  (i_s1_valid),
        .i_s1_error  (i_s1_error),
        .i_s1_flush  (i_s1_flush),
        .o_s1_busy   (o_s1_busy),
        .i_ctl       (ctl),
        .i_imm       (imm),
        .i_rs1_rdata (i_rs1_rdata),
        .i_rs2_rdata (i_rs2_rdata),
        .i_cf_req    (i_cf_req),
        .i_cf_target (i_cf_target),
        .i_cf_ack    (i_cf_ack),
        .o_s2_valid  (o_s2_valid),
        .o_s2        (o_s2),
        .i_s2_busy   (i_s2_busy)
    );

endmodule

`default_nettype wire

/* tb_decode_vectors.svh */
// Stimulus and expected values for the decode stage testbench
`ifndef TB_DECODE_VECTORS_SVH
`define TB_DECODE_VECTORS_SVH

// Columns: word, s1_error, busy cycles, flush, redirect, target,
//          rd, uop, fu (alu lsu cfu), trap, opr_a, a plus PC, opr_b, opr_c, c plus PC,
//          rs1 address, rs2 address
localparam int NUM_VECTORS = 23;

localparam vec_t VECTORS [NUM_VECTORS] = '{
    // ALU register, immediate, shifts and LUI
    '{32'h003100B3, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd1,  5'd1,  3'b100, 1'b0,
      32'h02020202, 1'b0, 32'h03030303, 32'h0, 1'b0, 5'd2, 5'd3},
    '{32'h40628233, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd4,  5'd2,  3'b100, 1'b0,
      32'h05050505, 1'b0, 32'h06060606, 32'h0, 1'b0, 5'd5, 5'd6},
    '{32'hFFF40393, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd7,  5'd1,  3'b100, 1'b0,
      32'h08080808, 1'b0, 32'hFFFFFFFF, 32'h0, 1'b0, 5'd8, 5'd0},
    '{32'h40355493, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd9,  5'd10, 3'b100, 1'b0,
      32'h0A0A0A0A, 1'b0, 32'h00000003, 32'h0, 1'b0, 5'd10, 5'd0},
    '{32'h01F61593, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd11, 5'd8,  3'b100, 1'b0,
      32'h0C0C0C0C, 1'b0, 32'h0000001F, 32'h0, 1'b0, 5'd12, 5'd0},
    '{32'h123456B7, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd13, 5'd4,  3'b100, 1'b0,
      32'h00000000, 1'b0, 32'h12345000, 32'h0, 1'b0, 5'd0, 5'd0},
    // Loads and stores
    '{32'h0087A703, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd14, 5'd23, 3'b010, 1'b0,
      32'h0F0F0F0F, 1'b0, 32'h00000008, 32'h0, 1'b0, 5'd15, 5'd0},
    '{32'hFFC8C803, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd16, 5'd3,  3'b010, 1'b0,
      32'h11111111, 1'b0, 32'hFFFFFFFC, 32'h0, 1'b0, 5'd17, 5'd0},
    '{32'h0129A623, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd0,  5'd14, 3'b010, 1'b0,
      32'h13131313, 1'b0, 32'h0000000C, 32'h12121212, 1'b0, 5'd19, 5'd18},
    '{32'hFF4A9F23, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd0,  5'd12, 3'b010, 1'b0,
      32'h15151515, 1'b0, 32'hFFFFFFFE, 32'h14141414, 1'b0, 5'd21, 5'd20},
    // Branches, jumps and AUIPC
    '{32'h00208863, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd0,  5'd1,  3'b001, 1'b0,
      32'h01010101, 1'b0, 32'h02020202, 32'h00000010, 1'b1, 5'd1, 5'd2},
    '{32'hFE419CE3, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd0,  5'd2,  3'b001, 1'b0,
      32'h03030303, 1'b0, 32'h04040404, 32'hFFFFFFF8, 1'b1, 5'd3, 5'd4},
    '{32'h001000EF, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd1,  5'd7,  3'b001, 1'b0,
      32'h00000000, 1'b0, 32'h00000000, 32'h00000800, 1'b1, 5'd0, 5'd0},
    '{32'h004302E7, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd5,  5'd8,  3'b001, 1'b0,
      32'h06060606, 1'b0, 32'h00000004, 32'h0, 1'b0, 5'd6, 5'd0},
    '{32'h00001397, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd7,  5'd1,  3'b100, 1'b0,
      32'h00001000, 1'b1, 32'h00000000, 32'h0, 1'b0, 5'd0, 5'd0},
    '{32'h00002417, 1'b0, 4'd0, 1'b0, 1'b1, 32'h00001000, 5'd8, 5'd1, 3'b100, 1'b0,
      32'h00002000, 1'b1, 32'h00000000, 32'h0, 1'b0, 5'd0, 5'd0},
    // Traps
    '{32'h0000007F, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd2,  5'd0,  3'b000, 1'b1,
      32'h00000000, 1'b0, 32'h00000000, 32'h0, 1'b0, 5'd0, 5'd0},
    '{32'h00000073, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd2,  5'd0,  3'b000, 1'b1,
      32'h00000000, 1'b0, 32'h00000000, 32'h0, 1'b0, 5'd0, 5'd0},
    '{32'h40628233, 1'b1, 4'd0, 1'b0, 1'b0, 32'h0, 5'd1,  5'd0,  3'b000, 1'b1,
      32'h05050505, 1'b0, 32'h06060606, 32'h0, 1'b0, 5'd5, 5'd6},
    '{32'h0000007F, 1'b1, 4'd0, 1'b0, 1'b0, 32'h0, 5'd1,  5'd0,  3'b000, 1'b1,
      32'h00000000, 1'b0, 32'h00000000, 32'h0, 1'b0, 5'd0, 5'd0},
    // Back-pressure, flush, then a PC check
    '{32'h00510093, 1'b0, 4'd3, 1'b0, 1'b0, 32'h0, 5'd1,  5'd1,  3'b100, 1'b0,
      32'h02020202, 1'b0, 32'h00000005, 32'h0, 1'b0, 5'd2, 5'd0},
    '{32'h003100B3, 1'b0, 4'd0, 1'b1, 1'b0, 32'h0, 5'd1,  5'd1,  3'b100, 1'b0,
      32'h02020202, 1'b0, 32'h03030303, 32'h0, 1'b0, 5'd2, 5'd3},
    '{32'h0040006F, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 5'd0,  5'd7,  3'b001, 1'b0,
      32'h00000000, 1'b0, 32'h00000000, 32'h00000004, 1'b1, 5'd0, 5'd0}
};

`endif

/* tb_decode.sv */
// Testbench for the RV32I decode stage, table driven with a register-file model
`default_nettype none
`timescale 1ns/10ps

module tb_decode;
    import decode_pkg::*;

    typedef struct packed {
        logic [31:0] word;
        logic        err;
        logic [3:0]  busy;     // Stall cycles after the item appears
        logic        flush;
        logic        redir;
        logic [31:0] target;
        logic [4:0]  rd;
        logic [4:0]  uop;
        logic [2:0]  fu;
        logic        trap;
        logic [31:0] a;
        logic        a_pc;     // Expected opr_a adds the PC
        logic [31:0] b;
        logic [31:0] c;
        logic        c_pc;     // Expected opr_c adds the PC
        logic [4:0]  rs1;      // Expected register file addresses
        logic [4:0]  rs2;
    } vec_t;

    `include "tb_decode_vectors.svh"

    localparam logic [31:0] FOLLOW_WORD = 32'h12300293;  // ADDI x5, x0, 0x123
    localparam int          WAIT_LIMIT  = 8;
    localparam int          NUM_RANDOM  = 8;

    logic            g_clk;
    logic            g_resetn;
    logic            i_s1_valid;
    logic [31:0]     i_s1_data;
    logic            i_s1_error;
    logic            i_s1_flush;
    logic            o_s1_busy;
    reg_addr_t       o_rs1_addr;
    reg_addr_t       o_rs2_addr;
    logic [31:0]     i_rs1_rdata;
    logic [31:0]     i_rs2_rdata;
    logic            i_cf_req;
    logic [31:0]     i_cf_target;
    logic            i_cf_ack;
    logic            o_s2_valid;
    dec_out_t        o_s2;
    logic            i_s2_busy;

    logic [31:0]     model_pc;
    int              errors;
    int              tests_run;
    int              tests_failed;
    integer          seed;

    frv_decode #(
        .PC_RESET_VALUE (32'h8000_0000)
    ) i_frv_decode (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_s1_valid  (i_s1_valid),
        .i_s1_data   (i_s1_data),
        .i_s1_error  (i_s1_error),
        .i_s1_flush  (i_s1_flush),
        .o_s1_busy   (o_s1_busy),
        .o_rs1_addr  (o_rs1_addr),
        .o_rs2_addr  (o_rs2_addr),
        .i_rs1_rdata (i_rs1_rdata),
        .i_rs2_rdata (i_rs2_rdata),
        .i_cf_req    (i_cf_req),
        .i_cf_target (i_cf_target),
        .i_cf_ack    (i_cf_ack),
        .o_s2_valid  (o_s2_valid),
        .o_s2        (o_s2),
        .i_s2_busy   (i_s2_busy)
    );

    // Register file model where x0 reads zero by the formula
    assign i_rs1_rdata = {27'd0, o_rs1_addr} * 32'h0101_0101;
    assign i_rs2_rdata = {27'd0, o_rs2_addr} * 32'h0101_0101;

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

    // Helpers
    // --------------------
    task automatic compare_value(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp)
            else begin
                $display("CHECK FAILED at %0t: %s got %h expected %h", $time, sig, got, exp);
                errors++;
            end
    endtask

    task automatic wait_for_valid();
        int cnt;
        cnt = 0;
        while (!o_s2_valid && cnt < WAIT_LIMIT) begin
            @(negedge g_clk);
            cnt++;
        end
        if (!o_s2_valid) begin
            $display("Timeout: no valid output from the decode stage at %0t", $time);
            errors++;
        end
    endtask

    // The word is still on i_s1_data, so the addresses belong to it
    task automatic check_item(input vec_t v, input logic [31:0] pc);
        compare_value("o_rs1_addr", {27'd0, o_rs1_addr}, {27'd0, v.rs1});
        compare_value("o_rs2_addr", {27'd0, o_rs2_addr}, {27'd0, v.rs2});
        compare_value("o_s2.rd", {27'd0, o_s2.rd}, {27'd0, v.rd});
        compare_value("o_s2.uop", {27'd0, o_s2.uop}, {27'd0, v.uop});
        compare_value("o_s2.fu", {29'd0, o_s2.fu}, {29'd0, v.fu});
        compare_value("o_s2.trap", {31'd0, o_s2.trap}, {31'd0, v.trap});
        compare_value("o_s2.opr_a", o_s2.opr_a, v.a + (v.a_pc ? pc : 32'd0));
        compare_value("o_s2.opr_b", o_s2.opr_b, v.b);
        compare_value("o_s2.opr_c", o_s2.opr_c, v.c + (v.c_pc ? pc : 32'd0));
    endtask

    // Applies one row; entered and left just after a falling edge
    task automatic apply_vector(input vec_t v, input int idx);
        int       n;
        int       errs_before;
        dec_out_t held;
        vec_t     follow;
        errs_before = errors;
        follow      = '0;
        if (v.redir) begin
            i_cf_req    = 1'b1;
            i_cf_ack    = 1'b1;
            i_cf_target = v.target;
            @(negedge g_clk);
            i_cf_req = 1'b0;
            i_cf_ack = 1'b0;
            model_pc = v.target;
        end
        i_s1_valid = 1'b1;
        i_s1_data  = v.word;
        i_s1_error = v.err;
        i_s1_flush = v.flush;
        i_s2_busy  = (v.busy != 4'd0);
        @(negedge g_clk);
        i_s1_valid = 1'b0;
        i_s1_error = 1'b0;
        if (v.flush) begin
            i_s1_flush = 1'b0;
            compare_value("o_s2_valid", {31'd0, o_s2_valid}, 32'd0);
        end else begin
            wait_for_valid();
            check_item(v, model_pc);
            model_pc = model_pc + 32'd4;
            if (v.busy != 4'd0) begin
                held       = o_s2;
                i_s1_valid = 1'b1;          // Next word waits behind the stall
                i_s1_data  = FOLLOW_WORD;
                for (n = 0; n < int'(v.busy); n++) begin
                    compare_value("o_s1_busy", {31'd0, o_s1_busy}, 32'd1);
                    assert (o_s2 === held)
                        else begin
                            $display("CHECK FAILED at %0t: o_s2 got %h expected %h",
                                     $time, o_s2, held);
                            errors++;
                        end
                    @(negedge g_clk);
                end
                i_s2_busy = 1'b0;
                @(negedge g_clk);
                i_s1_valid = 1'b0;
                wait_for_valid();
                follow.rd  = 5'd5;
                follow.uop = ALU_ADD;
                follow.fu  = 3'b100;
                follow.b   = 32'h0000_0123;
                check_item(follow, model_pc);
                model_pc = model_pc + 32'd4;
            end
            @(negedge g_clk);
            compare_value("o_s2_valid", {31'd0, o_s2_valid}, 32'd0);  // Not duplicated
        end
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("Test %0d word %h failed", idx, v.word);
        end else begin
            $display("Test %0d word %h passed", idx, v.word);
        end
    endtask

    // Random ADD or ADDI with random register fields
    function automatic vec_t random_vector(input logic [31:0] r, input logic [31:0] s);
        vec_t v;
        v      = '0;
        v.rd   = r[4:0];
        v.uop  = ALU_ADD;
        v.fu   = 3'b100;
        v.a    = {27'd0, r[9:5]} * 32'h0101_0101;
        v.rs1  = r[9:5];
        if (s[0]) begin
            v.word = {s[31:20], r[9:5], 3'b000, r[4:0], 7'b0010011};
            v.b    = {{20{s[31]}}, s[31:20]};
        end else begin
            v.word = {7'd0, r[14:10], r[9:5], 3'b000, r[4:0], 7'b0110011};
            v.b    = {27'd0, r[14:10]} * 32'h0101_0101;
            v.rs2  = r[14:10];
        end
        return v;
    endfunction

    // Main sequence
    // --------------------
    initial begin
        int          i;
        logic [31:0] r;
        logic [31:0] s;
        g_resetn     = 1'b0;
        i_s1_valid   = 1'b0;
        i_s1_data    = '0;
        i_s1_error   = 1'b0;
        i_s1_flush   = 1'b0;
        i_cf_req     = 1'b0;
        i_cf_target  = '0;
        i_cf_ack     = 1'b0;
        i_s2_busy    = 1'b0;
        model_pc     = 32'h8000_0000;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'hb97dfce0;

        repeat (3) @(negedge g_clk);
        g_resetn = 1'b1;
        compare_value("o_s2_valid", {31'd0, o_s2_valid}, 32'd0);

        for (i = 0; i < NUM_VECTORS; i++) begin
            apply_vector(VECTORS[i], i);
        end
        for (i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            s = $random(seed);
            apply_vector(random_vector(r, s), NUM_VECTORS + i);
        end

        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog on the whole run
    initial begin
        #(100 * 2000);
        $display("Timeout: the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
decode_pkg.sv
decode_control.sv
decode_immediate.sv
decode_stage.sv
frv_decode.sv
tb_decode.sv
+incdir+.

/* Makefile */
# Verilator build for the RV32I decode stage testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_decode
RTL_TOP    ?= frv_decode
FILELIST   ?= sim.f
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
